// File: sim.f
src/sysmon_pkg.sv
src/drp_if.sv
src/sysmon_regs.sv
src/sysmon_core.sv
src/sysmon_top.sv
dv/sysmon_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sysmon testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module sysmon_tb --Mdir obj_dir -o sysmon_sim \
  -f sim.f

./obj_dir/sysmon_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: dv/sysmon_tb.sv
`timescale 1ns/1ps

module sysmon_tb;

  localparam int HALF_PERIOD = 50;     // 100 ns clock
  localparam int QTR_PERIOD  = 25;     // sample point inside the low phase
  localparam int N_ITER      = 24;     // random loops per section
  // tests take about 2600 cycles so the limit leaves a wide margin
  localparam int MAX_CYCLES  = 20000;

  localparam sysmon_pkg::drp_addr_t LIM_ADDR [5] = '{
    sysmon_pkg::DRP_LIM_OT, sysmon_pkg::DRP_LIM_TEMP, sysmon_pkg::DRP_LIM_VCCINT,
    sysmon_pkg::DRP_LIM_VCCAUX, sysmon_pkg::DRP_LIM_VBRAM};  // indexed by alarm bit
  localparam sysmon_pkg::drp_addr_t MEAS_ADDR [4] = '{
    sysmon_pkg::DRP_TEMP, sysmon_pkg::DRP_VCCINT, sysmon_pkg::DRP_VCCAUX, sysmon_pkg::DRP_VBRAM};

  logic                     clk_usb;
  logic                     reset_i;
  sysmon_pkg::reg_addr_t    reg_address;
  sysmon_pkg::bytecnt_t     reg_bytecnt;
  sysmon_pkg::byte_t        reg_datai;
  logic                     reg_read;
  logic                     reg_write;
  sysmon_pkg::sensor_code_t temp_code;    // also the model's current codes
  sysmon_pkg::sensor_code_t vccint_code;
  sysmon_pkg::sensor_code_t vccaux_code;
  sysmon_pkg::sensor_code_t vbram_code;
  sysmon_pkg::byte_t        reg_datao;
  logic                     sysmon_error;
  sysmon_pkg::sensor_code_t sysmon_temp;

  sysmon_pkg::drp_data_t  lim_m [5];     // model limits by alarm bit
  sysmon_pkg::alarm_vec_t held_m;        // model sticky alarms
  integer                 seed;
  int                     fail_cnt = 0;
  int                     cycle_cnt = 0;

  sysmon_top dut_i (
    .clk_usb      (clk_usb),
    .reset_i      (reset_i),
    .reg_address  (reg_address),
    .reg_bytecnt  (reg_bytecnt),
    .reg_datai    (reg_datai),
    .reg_read     (reg_read),
    .reg_write    (reg_write),
    .temp_code    (temp_code),
    .vccint_code  (vccint_code),
    .vccaux_code  (vccaux_code),
    .vbram_code   (vbram_code),
    .reg_datao    (reg_datao),
    .sysmon_error (sysmon_error),
    .sysmon_temp  (sysmon_temp)
  );

  always #HALF_PERIOD clk_usb = ~clk_usb;

  // run length guard
  always @(posedge clk_usb) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // 12 bit code sits on top of four zero bits
  function automatic sysmon_pkg::drp_data_t to_drp_word(sysmon_pkg::sensor_code_t c);
    return {c, 4'h0};
  endfunction

  function automatic int lim_slot(sysmon_pkg::drp_addr_t a);
    case (a)
      sysmon_pkg::DRP_LIM_OT:     return 0;
      sysmon_pkg::DRP_LIM_TEMP:   return 1;
      sysmon_pkg::DRP_LIM_VCCINT: return 2;
      sysmon_pkg::DRP_LIM_VCCAUX: return 3;
      sysmon_pkg::DRP_LIM_VBRAM:  return 4;
      default:                    return -1;  // not a limit
    endcase
  endfunction

  // expected drp read word from model state
  function automatic sysmon_pkg::drp_data_t expected_read(sysmon_pkg::drp_addr_t a);
    case (a)
      sysmon_pkg::DRP_TEMP:   return to_drp_word(temp_code);
      sysmon_pkg::DRP_VCCINT: return to_drp_word(vccint_code);
      sysmon_pkg::DRP_VCCAUX: return to_drp_word(vccaux_code);
      sysmon_pkg::DRP_VBRAM:  return to_drp_word(vbram_code);
      default:                return (lim_slot(a) >= 0) ? lim_m[lim_slot(a)] : 16'h0000;
    endcase
  endfunction

  function automatic bit is_mapped(sysmon_pkg::drp_addr_t a);
    return (lim_slot(a) >= 0) || (a inside {sysmon_pkg::DRP_TEMP, sysmon_pkg::DRP_VCCINT,
                                            sysmon_pkg::DRP_VCCAUX, sysmon_pkg::DRP_VBRAM});
  endfunction

  // alarm when code strictly above limit
  function automatic sysmon_pkg::alarm_vec_t predict_alarms();
    sysmon_pkg::alarm_vec_t p;
    p[0] = to_drp_word(temp_code) > lim_m[0];    // ot shares the temp code
    p[1] = to_drp_word(temp_code) > lim_m[1];
    p[2] = to_drp_word(vccint_code) > lim_m[2];
    p[3] = to_drp_word(vccaux_code) > lim_m[3];
    p[4] = to_drp_word(vbram_code) > lim_m[4];
    return p;
  endfunction

  // called after every change of codes or limits
  task automatic update_held();
    held_m = held_m | predict_alarms();
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      fail_cnt++;
      $display("FAILED %s expected %h got %h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // all host tasks start and end on a falling edge
  task automatic host_write(input sysmon_pkg::reg_addr_t addr, input sysmon_pkg::bytecnt_t cnt,
                            input sysmon_pkg::byte_t data);
    reg_address = addr;
    reg_bytecnt = cnt;
    reg_datai   = data;
    reg_write   = 1'b1;
    @(negedge clk_usb);
    reg_write = 1'b0;
  endtask

  task automatic host_read(input sysmon_pkg::reg_addr_t addr, input sysmon_pkg::bytecnt_t cnt,
                           output sysmon_pkg::byte_t data);
    reg_address = addr;
    reg_bytecnt = cnt;
    reg_read    = 1'b1;
    #QTR_PERIOD;
    data = reg_datao;                  // combinational data is stable mid low phase
    @(negedge clk_usb);
    reg_read = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk_usb);
  endtask

  task automatic wait_idle(output int busy_n);
    sysmon_pkg::byte_t stat;
    busy_n = 0;
    host_read(sysmon_pkg::REG_STAT, 7'd0, stat);
    while (stat[7]) begin              // busy bit
      busy_n++;
      host_read(sysmon_pkg::REG_STAT, 7'd0, stat);
    end
  endtask

  task automatic drp_access(input sysmon_pkg::drp_addr_t addr, input logic wr);
    int busy_n;
    host_write(sysmon_pkg::REG_DRP_ADDR, 7'd0, {wr, addr});
    wait_idle(busy_n);
    check_equal("busy_cycles", 3, busy_n);  // den, two latency cycles
  endtask

  task automatic drp_read(input sysmon_pkg::drp_addr_t addr, output sysmon_pkg::drp_data_t d);
    sysmon_pkg::byte_t lo;
    sysmon_pkg::byte_t hi;
    drp_access(addr, 1'b0);
    host_read(sysmon_pkg::REG_DRP_DATA, 7'd0, lo);
    host_read(sysmon_pkg::REG_DRP_DATA, 7'd1, hi);
    d = {hi, lo};
  endtask

  // drp write plus model update
  task automatic drp_write(input sysmon_pkg::drp_addr_t addr, input sysmon_pkg::drp_data_t d);
    host_write(sysmon_pkg::REG_DRP_DATA, 7'd0, d[7:0]);
    host_write(sysmon_pkg::REG_DRP_DATA, 7'd1, d[15:8]);
    drp_access(addr, 1'b1);
    if (lim_slot(addr) >= 0) begin
      lim_m[lim_slot(addr)] = d;       // measurements ignore writes
    end
    update_held();
  endtask

  task automatic check_read(input sysmon_pkg::drp_addr_t addr);
    sysmon_pkg::drp_data_t got;
    drp_read(addr, got);
    check_equal($sformatf("drp_data[%h]", addr), 32'(expected_read(addr)), 32'(got));
  endtask

  task automatic check_stat();
    sysmon_pkg::byte_t stat;
    host_read(sysmon_pkg::REG_STAT, 7'd0, stat);
    check_equal("reg_stat", 32'(held_m), 32'(stat));  // busy expected low
    check_equal("sysmon_error", 32'(|held_m), 32'(sysmon_error));
  endtask

  task automatic drive_codes(input sysmon_pkg::sensor_code_t t, input sysmon_pkg::sensor_code_t vi,
                             input sysmon_pkg::sensor_code_t va, input sysmon_pkg::sensor_code_t vb);
    temp_code   = t;
    vccint_code = vi;
    vccaux_code = va;
    vbram_code  = vb;
    update_held();
  endtask

  task automatic new_codes();
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = next_rand();
    r1 = next_rand();
    drive_codes(r0[11:0], r0[27:16], r1[11:0], r1[27:16]);
  endtask

  task automatic clear_stat();
    host_write(sysmon_pkg::REG_STAT, 7'd0, 8'h00);
    held_m = '0;
    update_held();                     // a live condition sets again
    idle(1);
  endtask

  initial begin
    sysmon_pkg::drp_addr_t    a;
    sysmon_pkg::byte_t        b;
    sysmon_pkg::sensor_code_t t_prev;
    logic [31:0]              r;
    int                       k;
    int                       i;
    int                       busy_n;
    seed        = 32'h442b;
    clk_usb     = 1'b0;
    reset_i     = 1'b1;
    reg_address = '0;
    reg_bytecnt = '0;
    reg_datai   = '0;
    reg_read    = 1'b0;
    reg_write   = 1'b0;
    temp_code   = '0;
    vccint_code = '0;
    vccaux_code = '0;
    vbram_code  = '0;
    for (i = 0; i < 5; i++) begin
      lim_m[i] = 16'hFFF0;             // reset limit
    end
    held_m = '0;
    repeat (16) @(negedge clk_usb);
    reset_i = 1'b0;

    // reset state
    check_equal("sysmon_error", 0, 32'(sysmon_error));
    check_stat();
    for (i = 0; i < 5; i++) begin
      check_read(LIM_ADDR[i]);
    end

    // measurements read back left justified
    for (k = 0; k < N_ITER; k++) begin
      t_prev = temp_code;
      new_codes();
      #QTR_PERIOD;
      check_equal("sysmon_temp", 32'(t_prev), 32'(sysmon_temp));  // old code until the edge
      @(negedge clk_usb);              // one register stage
      check_equal("sysmon_temp", 32'(temp_code), 32'(sysmon_temp));
      for (i = 0; i < 4; i++) begin
        check_read(MEAS_ADDR[i]);
      end
    end

    // limit write and readback, ignored writes, unmapped reads
    for (k = 0; k < N_ITER; k++) begin
      r = next_rand();
      drp_write(LIM_ADDR[r % 5], r[31:16]);
      check_read(LIM_ADDR[r % 5]);
      r = next_rand();
      drp_write(MEAS_ADDR[r % 4], r[31:16]);
      check_read(MEAS_ADDR[r % 4]);
      do begin
        r = next_rand();
        a = r[6:0];
      end while (is_mapped(a));
      check_read(a);                   // zero
    end
    check_stat();

    // random limits and codes against predicted alarms
    for (k = 0; k < N_ITER; k++) begin
      clear_stat();
      new_codes();
      for (i = 0; i < 5; i++) begin
        r = next_rand();
        drp_write(LIM_ADDR[i], r[15:0]);
      end
      idle(2);
      check_stat();
    end

    // sticky alarms and clear
    for (i = 0; i < 5; i++) begin
      drp_write(LIM_ADDR[i], 16'h8000);
    end
    drive_codes(12'hFFF, 12'hFFF, 12'hFFF, 12'hFFF);
    idle(2);
    check_stat();
    host_read(sysmon_pkg::REG_STAT, 7'd0, b);
    check_equal("reg_stat", 32'h1f, 32'(b));  // every alarm raised
    drive_codes(12'h000, 12'h000, 12'h000, 12'h000);
    idle(2);
    check_stat();                      // still held
    clear_stat();
    check_stat();
    idle(8);
    check_stat();

    // address write while busy is dropped
    host_write(sysmon_pkg::REG_DRP_DATA, 7'd0, ~lim_m[0][7:0]);
    host_write(sysmon_pkg::REG_DRP_DATA, 7'd1, ~lim_m[0][15:8]);
    host_write(sysmon_pkg::REG_DRP_ADDR, 7'd0, {1'b0, sysmon_pkg::DRP_VCCAUX});
    host_write(sysmon_pkg::REG_DRP_ADDR, 7'd0, {1'b1, sysmon_pkg::DRP_LIM_OT});
    wait_idle(busy_n);
    host_read(sysmon_pkg::REG_DRP_ADDR, 7'd0, b);
    check_equal("drp_addr", 32'({1'b0, sysmon_pkg::DRP_VCCAUX}), 32'(b));
    check_read(sysmon_pkg::DRP_LIM_OT); // unchanged limit

    if (fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: src/sysmon_top.sv
`timescale 1ns/1ps

module sysmon_top (
  input  logic                     clk_usb,
  input  logic                     reset_i,
  input  sysmon_pkg::reg_addr_t    reg_address,   // host register select
  input  sysmon_pkg::bytecnt_t     reg_bytecnt,   // byte within the register
  input  sysmon_pkg::byte_t        reg_datai,     // host write data
  input  logic                     reg_read,      // host read strobe
  input  logic                     reg_write,     // host write strobe
  input  sysmon_pkg::sensor_code_t temp_code,     // digital sensor codes
  input  sysmon_pkg::sensor_code_t vccint_code,
  input  sysmon_pkg::sensor_code_t vccaux_code,
  input  sysmon_pkg::sensor_code_t vbram_code,
  output sysmon_pkg::byte_t        reg_datao,     // host read data
  output logic                     sysmon_error,  // OR of held alarms
  output sysmon_pkg::sensor_code_t sysmon_temp    // temp code one cycle late
);

  sysmon_pkg::alarm_vec_t alarms;  // raw core alarms into the sticky bits

  drp_if drp_bus ();               // register block to core

  sysmon_regs regs_i (
    .clk_usb      (clk_usb),
    .reset_i      (reset_i),
    .reg_address  (reg_address),
    .reg_bytecnt  (reg_bytecnt),
    .reg_datai    (reg_datai),
    .reg_read     (reg_read),
    .reg_write    (reg_write),
    .alarms       (alarms),
    .reg_datao    (reg_datao),
    .sysmon_error (sysmon_error),
    .drp          (drp_bus.master)
  );

  sysmon_core core_i (
    .clk_usb     (clk_usb),
    .reset_i     (reset_i),
    .temp_code   (temp_code),
    .vccint_code (vccint_code),
    .vccaux_code (vccaux_code),
    .vbram_code  (vbram_code),
    .alarms      (alarms),
    .temp_out    (sysmon_temp),
    .drp         (drp_bus.slave)
  );

endmodule

// File: src/sysmon_core.sv
`timescale 1ns/1ps

module sysmon_core (
  input  logic                     clk_usb,
  input  logic                     reset_i,
  input  sysmon_pkg::sensor_code_t temp_code,    // die temperature code
  input  sysmon_pkg::sensor_code_t vccint_code,
  input  sysmon_pkg::sensor_code_t vccaux_code,
  input  sysmon_pkg::sensor_code_t vbram_code,
  output sysmon_pkg::alarm_vec_t   alarms,       // live compare results
  output sysmon_pkg::sensor_code_t temp_out,     // registered temp code
  drp_if.slave                     drp
);

  // sampled sensor codes
  sysmon_pkg::sensor_code_t temp_q;
  sysmon_pkg::sensor_code_t vccint_q;
  sysmon_pkg::sensor_code_t vccaux_q;
  sysmon_pkg::sensor_code_t vbram_q;

  sysmon_pkg::drp_data_t lim  [sysmon_pkg::ALM_N];  // limit regs indexed by alarm bit
  sysmon_pkg::drp_data_t meas [sysmon_pkg::ALM_N];  // measurement seen by each alarm
  sysmon_pkg::drp_data_t rd_mux;                    // read data at den time

  logic [sysmon_pkg::DRP_LATENCY-1:0] vld_pipe;                          // den delay line
  sysmon_pkg::drp_data_t              dat_pipe [sysmon_pkg::DRP_LATENCY]; // read data delay

  // sensor codes registered every cycle
  always_ff @(posedge clk_usb) begin
    temp_q   <= temp_code;
    vccint_q <= vccint_code;
    vccaux_q <= vccaux_code;
    vbram_q  <= vbram_code;
  end

  assign temp_out = temp_q;

  // compare operands in drp word format
  always_comb begin
    meas[sysmon_pkg::ALM_OT]     = sysmon_pkg::left_justify(temp_q);  // ot uses temperature
    meas[sysmon_pkg::ALM_TEMP]   = sysmon_pkg::left_justify(temp_q);
    meas[sysmon_pkg::ALM_VCCINT] = sysmon_pkg::left_justify(vccint_q);
    meas[sysmon_pkg::ALM_VCCAUX] = sysmon_pkg::left_justify(vccaux_q);
    meas[sysmon_pkg::ALM_VBRAM]  = sysmon_pkg::left_justify(vbram_q);
  end

  // alarm when strictly above limit
  always_comb begin
    for (int i = 0; i < sysmon_pkg::ALM_N; i++) begin
      alarms[i] = meas[i] > lim[i];
    end
  end

  // limit register file
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      for (int i = 0; i < sysmon_pkg::ALM_N; i++) begin
        lim[i] <= sysmon_pkg::LIM_RESET;
      end
    end else if (drp.den && drp.dwe) begin
      case (drp.daddr)
        sysmon_pkg::DRP_LIM_TEMP:   lim[sysmon_pkg::ALM_TEMP]   <= drp.di;
        sysmon_pkg::DRP_LIM_VCCINT: lim[sysmon_pkg::ALM_VCCINT] <= drp.di;
        sysmon_pkg::DRP_LIM_VCCAUX: lim[sysmon_pkg::ALM_VCCAUX] <= drp.di;
        sysmon_pkg::DRP_LIM_OT:     lim[sysmon_pkg::ALM_OT]     <= drp.di;
        sysmon_pkg::DRP_LIM_VBRAM:  lim[sysmon_pkg::ALM_VBRAM]  <= drp.di;
        default: begin
          // measurements and unmapped space ignore writes
        end
      endcase
    end
  end

  // drp read decode
  always_comb begin
    case (drp.daddr)
      sysmon_pkg::DRP_TEMP:       rd_mux = sysmon_pkg::left_justify(temp_q);
      sysmon_pkg::DRP_VCCINT:     rd_mux = sysmon_pkg::left_justify(vccint_q);
      sysmon_pkg::DRP_VCCAUX:     rd_mux = sysmon_pkg::left_justify(vccaux_q);
      sysmon_pkg::DRP_VBRAM:      rd_mux = sysmon_pkg::left_justify(vbram_q);
      sysmon_pkg::DRP_LIM_TEMP:   rd_mux = lim[sysmon_pkg::ALM_TEMP];
      sysmon_pkg::DRP_LIM_VCCINT: rd_mux = lim[sysmon_pkg::ALM_VCCINT];
      sysmon_pkg::DRP_LIM_VCCAUX: rd_mux = lim[sysmon_pkg::ALM_VCCAUX];
      sysmon_pkg::DRP_LIM_OT:     rd_mux = lim[sysmon_pkg::ALM_OT];
      sysmon_pkg::DRP_LIM_VBRAM:  rd_mux = lim[sysmon_pkg::ALM_VBRAM];
      default:                    rd_mux = '0;  // unmapped reads as zero
    endcase
  end

  // ready timing
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= drp.den;
      for (int i = 1; i < sysmon_pkg::DRP_LATENCY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  // read data travels alongside the valid bits
  always_ff @(posedge clk_usb) begin
    dat_pipe[0] <= rd_mux;
    for (int i = 1; i < sysmon_pkg::DRP_LATENCY; i++) begin
      dat_pipe[i] <= dat_pipe[i-1];  // overlapping accesses keep their own data
    end
  end

  assign drp.drdy = vld_pipe[sysmon_pkg::DRP_LATENCY-1];
  assign drp.dout = dat_pipe[sysmon_pkg::DRP_LATENCY-1];

  // master never qualifies a write outside an access
  a_dwe_with_den: assert property (
    @(posedge clk_usb) disable iff (reset_i) drp.dwe |-> drp.den
  ) else $error("dwe asserted without den");

endmodule

// File: src/sysmon_regs.sv
`timescale 1ns/1ps

module sysmon_regs (
  input  logic                   clk_usb,
  input  logic                   reset_i,
  input  sysmon_pkg::reg_addr_t  reg_address,   // host register select
  input  sysmon_pkg::bytecnt_t   reg_bytecnt,   // byte within the register
  input  sysmon_pkg::byte_t      reg_datai,     // host write data
  input  logic                   reg_read,      // host read strobe
  input  logic                   reg_write,     // host write strobe
  input  sysmon_pkg::alarm_vec_t alarms,        // raw alarms from the core
  output sysmon_pkg::byte_t      reg_datao,     // host read data
  output logic                   sysmon_error,  // any held alarm
  drp_if.master                  drp
);

  sysmon_pkg::drp_addr_t  addr_q;      // last accepted drp address
  sysmon_pkg::drp_data_t  din_q;       // outgoing write word
  sysmon_pkg::drp_data_t  rdata_q;     // read hold word
  sysmon_pkg::alarm_vec_t alarm_hold;  // sticky alarms
  logic                   den_q;
  logic                   dwe_q;
  logic                   busy_q;      // access in flight

  logic wr_addr;                       // host write to drp address reg
  logic wr_data;                       // host write to drp data reg
  logic wr_stat;                       // host write to status reg
  logic start;                         // accepted drp access

  assign wr_addr = reg_write && (reg_address == sysmon_pkg::REG_DRP_ADDR);
  assign wr_data = reg_write && (reg_address == sysmon_pkg::REG_DRP_DATA);
  assign wr_stat = reg_write && (reg_address == sysmon_pkg::REG_STAT);
  assign start   = wr_addr && !busy_q;  // address writes while busy are dropped

  // drp master strobes
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      den_q  <= 1'b0;
      dwe_q  <= 1'b0;
      addr_q <= '0;
    end else begin
      den_q <= start;                                                 // single pulse
      dwe_q <= start && reg_datai[sysmon_pkg::DRP_WR_BIT];            // write when bit 7 set
      if (start) begin
        addr_q <= reg_datai[sysmon_pkg::DRP_ADDR_W-1:0];
      end
    end
  end

  // busy from accepted address write until drdy
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      busy_q <= 1'b0;
    end else if (start) begin
      busy_q <= 1'b1;
    end else if (drp.drdy) begin
      busy_q <= 1'b0;
    end
  end

  // write word built one byte at a time
  always_ff @(posedge clk_usb) begin
    if (wr_data) begin
      if (reg_bytecnt[0]) begin
        din_q[15:8] <= reg_datai;  // high byte
      end else begin
        din_q[7:0] <= reg_datai;   // low byte
      end
    end
  end

  // read hold word loaded on drdy
  always_ff @(posedge clk_usb) begin
    if (drp.drdy) begin
      rdata_q <= drp.dout;
    end
  end

  // transient alarms held until host clears them
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      alarm_hold <= '0;
    end else if (wr_stat) begin
      alarm_hold <= '0;                  // clear wins over a new alarm
    end else begin
      alarm_hold <= alarm_hold | alarms;
    end
  end

  assign sysmon_error = |alarm_hold;

  // host read mux
  always_comb begin
    reg_datao = '0;                      // zero when not reading
    if (reg_read) begin
      case (reg_address)
        sysmon_pkg::REG_DRP_ADDR: begin
          reg_datao = {1'b0, addr_q};
        end
        sysmon_pkg::REG_DRP_DATA: begin
          reg_datao = reg_bytecnt[0] ? rdata_q[15:8] : rdata_q[7:0];
        end
        sysmon_pkg::REG_STAT: begin
          reg_datao[sysmon_pkg::ALM_N-1:0]     = alarm_hold;
          reg_datao[sysmon_pkg::STAT_BUSY_BIT] = busy_q;
        end
        default: begin
          reg_datao = '0;                // unmapped
        end
      endcase
    end
  end

  assign drp.den   = den_q;
  assign drp.dwe   = dwe_q;
  assign drp.daddr = addr_q;
  assign drp.di    = din_q;

  // a new access only starts from idle
  a_den_from_idle: assert property (
    @(posedge clk_usb) disable iff (reset_i) $rose(drp.den) |-> !$past(busy_q)
  ) else $error("den raised while an access was in flight");

  // the core only answers an access we started
  a_drdy_in_busy: assert property (
    @(posedge clk_usb) disable iff (reset_i) drp.drdy |-> busy_q
  ) else $error("drdy outside of a pending access");

endmodule

// File: src/drp_if.sv
`timescale 1ns/1ps

// dynamic reconfiguration port between register block and monitor core
interface drp_if;

  logic                  den;    // one cycle access strobe
  logic                  dwe;    // write qualifier for den
  sysmon_pkg::drp_addr_t daddr;  // register select
  sysmon_pkg::drp_data_t di;     // write data
  sysmon_pkg::drp_data_t dout;   // read data valid with drdy
  logic                  drdy;   // one cycle access done

  modport master (
    output den,
    output dwe,
    output daddr,
    output di,
    input  dout,
    input  drdy
  );

  modport slave (
    input  den,
    input  dwe,
    input  daddr,
    input  di,
    output dout,
    output drdy
  );

endinterface

// File: src/sysmon_pkg.sv
package sysmon_pkg;

  // widths
  localparam int BYTECNT_W  = 7;             // host byte count width
  localparam int SENSOR_W   = 12;            // monitor adc code width
  localparam int DRP_DATA_W = 16;            // drp data word
  localparam int DRP_ADDR_W = 7;             // drp address space
  localparam int ALM_N      = 5;             // alarm outputs of the core

  typedef logic [7:0]            reg_addr_t;    // host register address
  typedef logic [7:0]            byte_t;        // host data byte
  typedef logic [BYTECNT_W-1:0]  bytecnt_t;     // only bit 0 selects the byte
  typedef logic [DRP_ADDR_W-1:0] drp_addr_t;
  typedef logic [DRP_DATA_W-1:0] drp_data_t;
  typedef logic [SENSOR_W-1:0]   sensor_code_t; // left justified in a drp word
  typedef logic [ALM_N-1:0]      alarm_vec_t;

  // alarm bit positions
  localparam int ALM_OT     = 0;             // over-temperature
  localparam int ALM_TEMP   = 1;             // user temperature limit
  localparam int ALM_VCCINT = 2;
  localparam int ALM_VCCAUX = 3;
  localparam int ALM_VBRAM  = 4;

  // host register map
  localparam reg_addr_t REG_DRP_ADDR = 8'h10;  // drp address plus write flag
  localparam reg_addr_t REG_DRP_DATA = 8'h11;  // 16 bit word, bytecnt 0 is low byte
  localparam reg_addr_t REG_STAT     = 8'h12;  // held alarms and busy

  localparam int DRP_WR_BIT    = 7;          // write flag in REG_DRP_ADDR
  localparam int STAT_BUSY_BIT = 7;          // busy flag in REG_STAT

  // drp measurement addresses, read only
  localparam drp_addr_t DRP_TEMP   = 7'h00;
  localparam drp_addr_t DRP_VCCINT = 7'h01;
  localparam drp_addr_t DRP_VCCAUX = 7'h02;
  localparam drp_addr_t DRP_VBRAM  = 7'h06;

  // drp limit addresses, read write
  localparam drp_addr_t DRP_LIM_TEMP   = 7'h50;
  localparam drp_addr_t DRP_LIM_VCCINT = 7'h51;
  localparam drp_addr_t DRP_LIM_VCCAUX = 7'h52;
  localparam drp_addr_t DRP_LIM_OT     = 7'h53;
  localparam drp_addr_t DRP_LIM_VBRAM  = 7'h56;

  localparam drp_data_t LIM_RESET = 16'hFFF0;  // every limit out of reset

  localparam int DRP_LATENCY = 2;            // den to drdy in cycles

  // sensor code into drp word format
  function automatic drp_data_t left_justify(sensor_code_t code);
    return {code, {(DRP_DATA_W - SENSOR_W){1'b0}}};  // zero fill below the code
  endfunction

endpackage
